//--- run_sim.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it, and scan the log.
set -u

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_icache -f sources.f -Mdir obj_dir -o tb_icache_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/tb_icache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q -F '*** FAILED ***' "$LOG"; then
  echo "simulation reported failure, see $LOG"
  exit 1
fi

echo "simulation finished without failure"
exit 0

//--- source/icache_bus_pkg.sv
/*
  Payload and state types passed between the lookup stage and the refill unit.
  Word 0 of a line sits at the lowest address.
*/
package icache_bus_pkg;

  import icache_cfg_pkg::*;

  // one cache line, word 0 at the line base address
  typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

  // instructions returned per response, lowest address first
  typedef logic [FETCH_WIDTH-1:0][WORD_W-1:0] fetch_group_t;

  // refill FSM
  typedef enum logic [1:0] {
    IDLE,
    MISS,
    REFILL
  } refill_state_t;

endpackage

//--- source/icache_cfg_pkg.sv
/*
  Cache geometry for a 2-way, 16-set, 16-byte-line instruction cache.
  Addresses are physical byte addresses. Fetches are word aligned.
  WORDS_PER_LINE must be a multiple of FETCH_WIDTH.
*/
package icache_cfg_pkg;

  // ================================================
  // geometry
  // ================================================
  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 32;
  localparam int WAY_NUM        = 2;
  localparam int LINE_BYTES     = 16;
  localparam int WORDS_PER_LINE = LINE_BYTES / (WORD_W / 8);
  localparam int SET_NUM        = 16;
  localparam int IDX_W          = $clog2(SET_NUM);
  localparam int OFS_W          = $clog2(LINE_BYTES);
  localparam int TAG_W          = ADDR_W - IDX_W - OFS_W;
  localparam int FETCH_WIDTH    = 2;

  // fetch group select bits inside the byte offset
  localparam int GRP_W   = $clog2(WORDS_PER_LINE / FETCH_WIDTH);
  localparam int GRP_LSB = OFS_W - GRP_W;

  // beat counter for one line burst
  localparam int BEAT_W = $clog2(WORDS_PER_LINE);

  typedef logic [TAG_W-1:0]           tag_t;
  typedef logic [IDX_W-1:0]           idx_t;
  typedef logic [$clog2(WAY_NUM)-1:0] way_t;

  // address field extraction
  function automatic tag_t tag_of(input logic [ADDR_W-1:0] addr);
    return addr[ADDR_W-1 -: TAG_W];
  endfunction

  function automatic idx_t idx_of(input logic [ADDR_W-1:0] addr);
    return addr[OFS_W +: IDX_W];
  endfunction

endpackage

//--- source/icache_lookup.sv
/*
  Fetch request stage with tag compare and hit response.
  The response is combinational from stage 1, one cycle after acceptance.
  rsp_addr_o is aligned down to the fetch group. Two ways only for the PLRU.
*/
module icache_lookup
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush_i,
  // fetch request
  input  logic                req_valid_i,
  input  logic [ADDR_W-1:0]   req_addr_i,
  output logic                req_ready_o,
  // fetch response
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  output logic [ADDR_W-1:0]   rsp_addr_o,
  output fetch_group_t        rsp_instr_o,
  // way RAM read side
  output idx_t                ram_raddr_o,
  input  tag_t [WAY_NUM-1:0]  tag_rdata_i,
  input  line_t [WAY_NUM-1:0] line_rdata_i,
  // refill interface
  output logic                miss_o,
  output logic [ADDR_W-1:0]   miss_addr_o,
  output way_t                victim_o,
  input  logic                busy_i,
  input  logic                fill_we_i,
  input  way_t                fill_way_i,
  input  idx_t                fill_idx_i
);

  logic                            init_q;
  logic                            s1_valid;
  logic [ADDR_W-1:0]               s1_addr;
  idx_t                            s1_idx;
  tag_t                            s1_tag;
  logic                            s1_ready;
  logic                            accept;
  logic [WAY_NUM-1:0]              match;
  logic                            hit;
  way_t                            hit_way;
  logic [SET_NUM-1:0][WAY_NUM-1:0] valid_q;
  way_t [SET_NUM-1:0]              plru_q;
  line_t                           sel_line;
  logic [GRP_W-1:0]                grp_sel;

  // ================================================
  // request acceptance
  // ================================================
  assign s1_idx   = idx_of(s1_addr);
  assign s1_tag   = tag_of(s1_addr);
  assign s1_ready = ~s1_valid | (hit & rsp_ready_i);

  // held low for the first cycle out of reset
  assign req_ready_o = init_q & s1_ready & ~flush_i;
  assign accept      = req_valid_i & req_ready_o;

  // stalled stage keeps re-reading its own set
  assign ram_raddr_o = s1_ready ? idx_of(req_addr_i) : s1_idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_q   <= 1'b0;
      s1_valid <= 1'b0;
    end else begin
      init_q <= 1'b1;
      if (flush_i) begin
        s1_valid <= 1'b0;
      end else if (s1_ready) begin
        s1_valid <= accept;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_addr <= req_addr_i;
    end
  end

  // ================================================
  // tag compare and response
  // ================================================
  always_comb begin
    for (int w = 0; w < WAY_NUM; w++) begin
      match[w] = valid_q[s1_idx][w] & (tag_rdata_i[w] == s1_tag);
    end
  end

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAY_NUM; w++) begin
      if (match[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  assign hit = |match;

  assign grp_sel  = s1_addr[GRP_LSB +: GRP_W];
  assign sel_line = line_rdata_i[hit_way];

  always_comb begin
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      rsp_instr_o[i] = sel_line[grp_sel * FETCH_WIDTH + i];
    end
  end

  assign rsp_valid_o = s1_valid & hit & ~flush_i;
  assign rsp_addr_o  = {s1_addr[ADDR_W-1:GRP_LSB], {GRP_LSB{1'b0}}};

  // one refill at a time, the miss waits for an idle refill unit
  assign miss_o      = s1_valid & ~hit & ~busy_i & ~flush_i;
  assign miss_addr_o = s1_addr;
  assign victim_o    = plru_q[s1_idx];

  // ================================================
  // valid bits and PLRU
  // ================================================
  // plru bit names the next victim of the set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      plru_q  <= '0;
    end else begin
      if (rsp_valid_o && rsp_ready_i) begin
        plru_q[s1_idx] <= ~hit_way;
      end
      if (fill_we_i) begin
        valid_q[fill_idx_i][fill_way_i] <= 1'b1;
        plru_q[fill_idx_i]              <= ~fill_way_i;
      end
    end
  end

  // a line is never present in both ways of a set
  a_match_onehot : assert property (
    @(posedge clk) disable iff (!rst_n)
    s1_valid |-> $onehot0(match)
  ) else $error("more than one way matches set %0d", s1_idx);

endmodule

//--- source/icache_refill.sv
/*
  Miss handling with one outstanding line burst on the read port.
  The memory returns exactly WORDS_PER_LINE beats, last one flagged.
  A flushed refill still drains its burst but writes nothing.
*/
module icache_refill
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush_i,
  // miss from lookup
  input  logic              miss_i,
  input  logic [ADDR_W-1:0] miss_addr_i,
  input  way_t              victim_i,
  output logic              busy_o,
  // memory read port
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  output logic [ADDR_W-1:0] mem_ar_addr_o,
  input  logic              mem_r_valid_i,
  input  logic [WORD_W-1:0] mem_r_data_i,
  input  logic              mem_r_last_i,
  output logic              mem_r_ready_o,
  // way RAM write side
  output logic              fill_we_o,
  output way_t              fill_way_o,
  output idx_t              fill_idx_o,
  output tag_t              fill_tag_o,
  output line_t             fill_line_o
);

  refill_state_t     state_q;
  logic [ADDR_W-1:0] addr_q;
  way_t              way_q;
  logic              drop_q;
  logic [BEAT_W-1:0] beat_q;
  line_t             buf_q;
  logic              beat_ok;

  assign beat_ok = (state_q == REFILL) & mem_r_valid_i;

  // ================================================
  // FSM
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      drop_q  <= 1'b0;
      beat_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (miss_i && !flush_i) begin
            state_q <= MISS;
            drop_q  <= 1'b0;
            beat_q  <= '0;
          end
        end
        MISS: begin
          if (mem_ar_ready_i) begin
            state_q <= REFILL;
          end
        end
        REFILL: begin
          if (mem_r_valid_i) begin
            beat_q <= beat_q + 1'b1;
            if (mem_r_last_i) begin
              state_q <= IDLE;
            end
          end
        end
        default: state_q <= IDLE;
      endcase

      // requester is gone, finish the burst quietly
      if (flush_i && (state_q != IDLE)) begin
        drop_q <= 1'b1;
      end
    end
  end

  // miss context and line buffer
  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && miss_i) begin
      addr_q <= miss_addr_i;
      way_q  <= victim_i;
    end
    if (beat_ok) begin
      buf_q[beat_q] <= mem_r_data_i;
    end
  end

  // ================================================
  // outputs
  // ================================================
  assign busy_o         = (state_q != IDLE);
  assign mem_ar_valid_o = (state_q == MISS);
  assign mem_ar_addr_o  = {addr_q[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
  assign mem_r_ready_o  = (state_q == REFILL);

  // line written straight from the last beat
  assign fill_we_o  = beat_ok & mem_r_last_i & ~drop_q & ~flush_i;
  assign fill_way_o = way_q;
  assign fill_idx_o = idx_of(addr_q);
  assign fill_tag_o = tag_of(addr_q);

  always_comb begin
    fill_line_o         = buf_q;
    fill_line_o[beat_q] = mem_r_data_i;
  end

  // read request held until the memory takes it
  a_ar_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_addr_o)
  ) else $error("read address changed before acceptance");

  // burst length agrees with the line size
  a_last_beat : assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_r_valid_i && mem_r_ready_o |->
      (mem_r_last_i == (beat_q == BEAT_W'(WORDS_PER_LINE - 1)))
  ) else $error("last flag on beat %0d", beat_q);

endmodule

//--- source/icache_top.sv
/*
  Instruction cache top level, 2 ways with one tag RAM and one line RAM each.
  Fetch addresses are used as physical addresses, no uncached path.
*/
module icache_top
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush_i,
  // fetch request
  input  logic              req_valid_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  output logic              req_ready_o,
  // fetch response
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output logic [ADDR_W-1:0] rsp_addr_o,
  output fetch_group_t      rsp_instr_o,
  // memory read port
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  output logic [ADDR_W-1:0] mem_ar_addr_o,
  input  logic              mem_r_valid_i,
  input  logic [WORD_W-1:0] mem_r_data_i,
  input  logic              mem_r_last_i,
  output logic              mem_r_ready_o
);

  idx_t                ram_raddr;
  tag_t [WAY_NUM-1:0]  tag_rdata;
  line_t [WAY_NUM-1:0] line_rdata;
  logic                miss;
  logic [ADDR_W-1:0]   miss_addr;
  way_t                victim;
  logic                busy;
  logic                fill_we;
  way_t                fill_way;
  idx_t                fill_idx;
  tag_t                fill_tag;
  line_t               fill_line;

  icache_lookup u_lookup (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .req_ready_o  (req_ready_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_addr_o   (rsp_addr_o),
    .rsp_instr_o  (rsp_instr_o),
    .ram_raddr_o  (ram_raddr),
    .tag_rdata_i  (tag_rdata),
    .line_rdata_i (line_rdata),
    .miss_o       (miss),
    .miss_addr_o  (miss_addr),
    .victim_o     (victim),
    .busy_i       (busy),
    .fill_we_i    (fill_we),
    .fill_way_i   (fill_way),
    .fill_idx_i   (fill_idx)
  );

  icache_refill u_refill (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush_i),
    .miss_i         (miss),
    .miss_addr_i    (miss_addr),
    .victim_i       (victim),
    .busy_o         (busy),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_data_i   (mem_r_data_i),
    .mem_r_last_i   (mem_r_last_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .fill_we_o      (fill_we),
    .fill_way_o     (fill_way),
    .fill_idx_o     (fill_idx),
    .fill_tag_o     (fill_tag),
    .fill_line_o    (fill_line)
  );

  // per-way storage, written only for the victim way
  for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
    icache_way_ram #(
      .entry_t (tag_t)
    ) u_tag_ram (
      .clk     (clk),
      .we_i    (fill_we & (fill_way == way_t'(w))),
      .waddr_i (fill_idx),
      .wdata_i (fill_tag),
      .raddr_i (ram_raddr),
      .rdata_o (tag_rdata[w])
    );

    icache_way_ram #(
      .entry_t (line_t)
    ) u_line_ram (
      .clk     (clk),
      .we_i    (fill_we & (fill_way == way_t'(w))),
      .waddr_i (fill_idx),
      .wdata_i (fill_line),
      .raddr_i (ram_raddr),
      .rdata_o (line_rdata[w])
    );
  end

endmodule

//--- source/icache_way_ram.sv
/*
  One way of the cache storage, SET_NUM entries of entry_t.
  Read data is registered. Same-index write and read return the new entry.
  Contents are undefined after reset.
*/
module icache_way_ram
  import icache_cfg_pkg::*;
#(
  parameter type entry_t = logic
) (
  input  logic   clk,
  input  logic   we_i,
  input  idx_t   waddr_i,
  input  entry_t wdata_i,
  input  idx_t   raddr_i,
  output entry_t rdata_o
);

  entry_t mem [SET_NUM];

  // write port
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // registered read, write-first on collision
  always_ff @(posedge clk) begin
    if (we_i && (waddr_i == raddr_i)) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

//--- sources.f
source/icache_cfg_pkg.sv
source/icache_bus_pkg.sv
source/icache_way_ram.sv
source/icache_lookup.sv
source/icache_refill.sv
source/icache_top.sv
test/tb_mem_model.sv
test/tb_icache.sv

//--- test/tb_icache.sv
/*
  Directed tests for the instruction cache with tb_mem_model as memory.
  Inputs change shortly after the rising edge. Outputs are read at the falling edge.
  Each wait gives up after TIMEOUT_CYC cycles and counts as an error.
*/
module tb_icache
  import icache_cfg_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYC = 200;
  localparam int DRIVE_DLY   = 2;
  localparam int GRP_BITS    = FETCH_WIDTH * WORD_W;
  localparam int GROUP_BYTES = GRP_BITS / 8;

  // P Q R share set 5 with distinct tags
  // F sits off its line base
  localparam logic [ADDR_W-1:0] ADDR_A = 32'h0000_2040;
  localparam logic [ADDR_W-1:0] ADDR_P = 32'h0001_0050;
  localparam logic [ADDR_W-1:0] ADDR_Q = 32'h0002_0050;
  localparam logic [ADDR_W-1:0] ADDR_R = 32'h0003_0050;
  localparam logic [ADDR_W-1:0] ADDR_F = 32'h0004_009c;

  logic                clk;
  logic                rst_n;
  logic                flush_i;
  logic                req_valid_i;
  logic [ADDR_W-1:0]   req_addr_i;
  logic                req_ready_o;
  logic                rsp_valid_o;
  logic                rsp_ready_i;
  logic [ADDR_W-1:0]   rsp_addr_o;
  logic [GRP_BITS-1:0] rsp_instr_o;
  logic                mem_ar_valid_o;
  logic                mem_ar_ready_i;
  logic [ADDR_W-1:0]   mem_ar_addr_o;
  logic                mem_r_valid_i;
  logic [WORD_W-1:0]   mem_r_data_i;
  logic                mem_r_last_i;
  logic                mem_r_ready_o;
  logic [31:0]         burst_cnt;
  int                  errors;
  int                  checks;

  icache_top u_dut (.*);

  tb_mem_model u_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .ar_valid_i  (mem_ar_valid_o),
    .ar_ready_o  (mem_ar_ready_i),
    .ar_addr_i   (mem_ar_addr_o),
    .r_valid_o   (mem_r_valid_i),
    .r_data_o    (mem_r_data_i),
    .r_last_o    (mem_r_last_i),
    .r_ready_i   (mem_r_ready_o),
    .burst_cnt_o (burst_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==================================================
  // helpers
  // ==================================================
  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_fail(input string msg);
    errors++;
    $display("failure at %0t: %s", $time, msg);
  endtask

  task automatic step();
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [ADDR_W-1:0] group_base(input logic [ADDR_W-1:0] addr);
    return addr & ~ADDR_W'(GROUP_BYTES - 1);
  endfunction

  // lowest address in the low word
  function automatic logic [GRP_BITS-1:0] expected_group(input logic [ADDR_W-1:0] addr);
    logic [GRP_BITS-1:0] grp;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      grp[i*WORD_W +: WORD_W] = u_mem.data_word(group_base(addr) + ADDR_W'(i * WORD_W / 8));
    end
    return grp;
  endfunction

  task automatic send_req(input logic [ADDR_W-1:0] addr);
    int n;
    n           = 0;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    @(negedge clk);
    while (!req_ready_o && n < TIMEOUT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (!req_ready_o) begin
      report_fail($sformatf("request for 0x%08h was never accepted", addr));
    end
    step();
    req_valid_i = 1'b0;
  endtask

  // cycles counts falling edges from acceptance to the response
  task automatic wait_rsp(output int cycles, output logic [ADDR_W-1:0] addr,
                          output logic [GRP_BITS-1:0] instr);
    cycles = 1;
    @(negedge clk);
    while (!rsp_valid_o && cycles < TIMEOUT_CYC) begin
      @(negedge clk);
      cycles++;
    end
    if (!rsp_valid_o) begin
      report_fail("no fetch response arrived");
    end
    addr  = rsp_addr_o;
    instr = rsp_instr_o;
    step();
  endtask

  // exp_bursts below zero means hit or miss is not known
  task automatic fetch_check(input logic [ADDR_W-1:0] addr, input int exp_bursts);
    logic [31:0]         cnt0;
    int                  cycles;
    logic [ADDR_W-1:0]   got_addr;
    logic [GRP_BITS-1:0] got_instr;
    cnt0 = burst_cnt;
    send_req(addr);
    wait_rsp(cycles, got_addr, got_instr);
    check_val("rsp_addr_o", 64'(got_addr), 64'(group_base(addr)));
    check_val("rsp_instr_o", 64'(got_instr), 64'(expected_group(addr)));
    if (exp_bursts >= 0) begin
      check_val("burst count", 64'(burst_cnt - cnt0), 64'(exp_bursts));
      if (exp_bursts == 0) begin
        check_val("hit latency", 64'(cycles), 64'd1);
      end
    end
  endtask

  // ==================================================
  // tests
  // ==================================================
  task automatic test_cold_miss();
    fetch_check(ADDR_A, 1);
  endtask

  task automatic test_hit();
    fetch_check(ADDR_A + 8, 0);
    fetch_check(ADDR_A + 4, 0);
    // two requests on consecutive cycles
    req_valid_i = 1'b1;
    req_addr_i  = ADDR_A;
    @(negedge clk);
    check_val("req_ready_o", 64'(req_ready_o), 64'd1);
    step();
    req_addr_i = ADDR_A + 8;
    @(negedge clk);
    check_val("rsp_valid_o", 64'(rsp_valid_o), 64'd1);
    check_val("rsp_addr_o", 64'(rsp_addr_o), 64'(ADDR_A));
    check_val("rsp_instr_o", 64'(rsp_instr_o), 64'(expected_group(ADDR_A)));
    check_val("req_ready_o", 64'(req_ready_o), 64'd1);
    step();
    req_valid_i = 1'b0;
    @(negedge clk);
    check_val("rsp_valid_o", 64'(rsp_valid_o), 64'd1);
    check_val("rsp_addr_o", 64'(rsp_addr_o), 64'(ADDR_A + 8));
    check_val("rsp_instr_o", 64'(rsp_instr_o), 64'(expected_group(ADDR_A + 8)));
    step();
  endtask

  task automatic test_plru();
    fetch_check(ADDR_P, 1);
    fetch_check(ADDR_Q, 1);
    fetch_check(ADDR_P, 0);
    // Q is least recently used now
    fetch_check(ADDR_R, 1);
    fetch_check(ADDR_P, 0);
    fetch_check(ADDR_Q, 1);
  endtask

  task automatic test_backpressure();
    rsp_ready_i = 1'b0;
    send_req(ADDR_A + 8);
    repeat (6) begin
      @(negedge clk);
      check_val("rsp_valid_o", 64'(rsp_valid_o), 64'd1);
      check_val("rsp_addr_o", 64'(rsp_addr_o), 64'(group_base(ADDR_A + 8)));
      check_val("rsp_instr_o", 64'(rsp_instr_o), 64'(expected_group(ADDR_A + 8)));
      check_val("req_ready_o", 64'(req_ready_o), 64'd0);
    end
    step();
    rsp_ready_i = 1'b1;
    @(negedge clk);
    check_val("rsp_valid_o", 64'(rsp_valid_o), 64'd1);
    step();
    @(negedge clk);
    check_val("rsp_valid_o", 64'(rsp_valid_o), 64'd0);
    step();
  endtask

  task automatic test_flush();
    logic [31:0] cnt0;
    int          n;
    cnt0 = burst_cnt;
    n    = 0;
    send_req(ADDR_F);
    @(negedge clk);
    while (!mem_ar_valid_o && n < TIMEOUT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (!mem_ar_valid_o) begin
      report_fail("refill never requested the missing line");
    end
    check_val("mem_ar_addr_o", 64'(mem_ar_addr_o), 64'(ADDR_F & ~ADDR_W'(LINE_BYTES - 1)));
    step();
    flush_i = 1'b1;
    step();
    flush_i = 1'b0;
    // dropped burst still drains on the read port
    n = 0;
    @(negedge clk);
    while ((burst_cnt == cnt0 || mem_r_ready_o) && n < TIMEOUT_CYC) begin
      if (rsp_valid_o) begin
        report_fail("response seen for a flushed fetch");
      end
      @(negedge clk);
      n++;
    end
    if (burst_cnt == cnt0 || mem_r_ready_o) begin
      report_fail("flushed burst did not finish");
    end
    check_val("rsp_valid_o", 64'(rsp_valid_o), 64'd0);
    step();
    fetch_check(ADDR_F, 1);
  endtask

  task automatic test_random();
    logic [31:0] seed;
    seed = 32'h1f7f;
    repeat (40) begin
      seed = xorshift32(seed);
      fetch_check(seed & 32'h0000_03fc, -1);
    end
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    errors      = 0;
    checks      = 0;
    rst_n       = 1'b0;
    flush_i     = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    rsp_ready_i = 1'b1;
    repeat (3) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;
    // nothing is ready in the first cycle out of reset
    @(negedge clk);
    check_val("req_ready_o", 64'(req_ready_o), 64'd0);
    check_val("rsp_valid_o", 64'(rsp_valid_o), 64'd0);
    check_val("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'd0);
    check_val("mem_r_ready_o", 64'(mem_r_ready_o), 64'd0);
    step();

    test_cold_miss();
    test_hit();
    test_plru();
    test_backpressure();
    test_flush();
    test_random();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- test/tb_mem_model.sv
/*
  Burst read memory for the cache testbench, one burst at a time.
  Word data follows an address rule, there is no storage behind it.
  ar_ready rises after a fixed wait. burst_cnt_o counts accepted bursts.
*/
module tb_mem_model
  import icache_cfg_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  logic [ADDR_W-1:0] ar_addr_i,
  output logic              r_valid_o,
  output logic [WORD_W-1:0] r_data_o,
  output logic              r_last_o,
  input  logic              r_ready_i,
  output logic [31:0]       burst_cnt_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int                AR_DELAY = 2;
  localparam logic [WORD_W-1:0] DATA_KEY = 32'h5a5a_0000;

  logic [ADDR_W-1:0] line_base;
  logic [ADDR_W-1:0] base_q;
  int                beat_q;
  int                wait_q;

  // word stored at a byte address
  function automatic logic [WORD_W-1:0] data_word(input logic [ADDR_W-1:0] addr);
    return addr ^ DATA_KEY;
  endfunction

  assign line_base = {ar_addr_i[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_ready_o  <= 1'b0;
      r_valid_o   <= 1'b0;
      r_data_o    <= '0;
      r_last_o    <= 1'b0;
      base_q      <= '0;
      beat_q      <= 0;
      wait_q      <= 0;
      burst_cnt_o <= '0;
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        // address taken, first beat goes out next cycle
        ar_ready_o  <= 1'b0;
        wait_q      <= 0;
        base_q      <= line_base;
        burst_cnt_o <= burst_cnt_o + 32'd1;
        r_valid_o   <= 1'b1;
        r_data_o    <= data_word(line_base);
        r_last_o    <= (WORDS_PER_LINE == 1);
        beat_q      <= 1;
      end else if (ar_valid_i && !r_valid_o) begin
        if (wait_q == AR_DELAY - 1) begin
          ar_ready_o <= 1'b1;
        end else begin
          wait_q <= wait_q + 1;
        end
      end
      if (r_valid_o && r_ready_i) begin
        if (r_last_o) begin
          r_valid_o <= 1'b0;
          r_last_o  <= 1'b0;
        end else begin
          r_data_o <= data_word(base_q + ADDR_W'(4 * beat_q));
          r_last_o <= (beat_q == WORDS_PER_LINE - 1);
          beat_q   <= beat_q + 1;
        end
      end
    end
  end

endmodule
